//--- rtl/dma_pkg.sv
// shared widths and types; addresses and lengths are bytes, transfers must be word aligned
package dma_pkg;

  // memory word and byte address widths
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned AddrWidth   = 16;
  localparam int unsigned StrbBytes   = DataWidth / 8;
  localparam int unsigned OffsetWidth = $clog2(StrbBytes);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  // one extra bit so a full address space copy fits
  typedef logic [AddrWidth:0]   len_t;
  typedef logic [7:0]           beats_t;

  // copy request as seen at the backend input
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } dma_req_t;

  // one page-safe burst, last marks the final burst of a request
  typedef struct packed {
    addr_t  addr;
    beats_t beats;
    logic   last;
  } burst_desc_t;

  // simple request/grant memory port
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

endpackage

//--- rtl/dma_fifo.sv
// fall-through FIFO; full_o reads high during reset and for the first cycle after it
`timescale 1ns/1ps

module dma_fifo #(
  parameter int unsigned Depth  = 4,
  parameter type         elem_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  elem_t                      data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output elem_t                      data_o,
  output logic                       empty_o,
  output logic [$clog2(Depth+1)-1:0] usage_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  elem_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q, cnt_d;
  logic                full_q;

  // occupancy after this cycle's push and pop
  assign cnt_d = cnt_q + CntWidth'(push_i) - CntWidth'(pop_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      // refuse pushes until reset is over
      full_q   <= 1'b1;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q  <= cnt_d;
      full_q <= (cnt_d == CntWidth'(Depth));
    end
  end

  // storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // head word shows one cycle after its push
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = full_q;
  assign usage_o = cnt_q;

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- rtl/dma_burst_splitter.sv
// one request at a time; PageBytes a power of two, MaxBeats at most 255
`timescale 1ns/1ps

module dma_burst_splitter import dma_pkg::*; #(
  parameter int unsigned MaxBeats  = 8,
  parameter int unsigned PageBytes = 64
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dma_req_t    req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output burst_desc_t rd_desc_o,
  output logic        rd_valid_o,
  input  logic        rd_ready_i,
  output burst_desc_t wr_desc_o,
  output logic        wr_valid_o,
  input  logic        wr_ready_i,
  input  logic        trans_complete_i,
  output logic        busy_o
);

  localparam int unsigned PageBits = $clog2(PageBytes);
  localparam len_t        MaxBytes = len_t'(MaxBeats * StrbBytes);

  // current position inside the request
  addr_t  src_q, dst_q;
  len_t   rem_q;
  // per side: burst offered but not yet taken
  logic   rd_pend_q, wr_pend_q;
  logic   in_flight_q;

  len_t   src_room, dst_room, burst_bytes;
  beats_t beats;
  logic   last_burst;
  logic   take, take_nz;
  logic   rd_left, wr_left, pair_done;

  // ----------------------------------------------------------
  // request intake
  // ----------------------------------------------------------
  // next request only once the previous one has fully retired
  assign req_ready_o = !in_flight_q || trans_complete_i;
  assign take        = req_valid_i && req_ready_o;
  // zero-byte requests are simply popped
  assign take_nz     = take && (req_i.num_bytes != '0);

  // ----------------------------------------------------------
  // burst cutting
  // ----------------------------------------------------------
  always_comb begin
    // bytes left before the next page end on either side
    src_room    = len_t'(PageBytes) - len_t'(src_q[PageBits-1:0]);
    dst_room    = len_t'(PageBytes) - len_t'(dst_q[PageBits-1:0]);
    burst_bytes = rem_q;
    if (MaxBytes < burst_bytes) begin
      burst_bytes = MaxBytes;
    end
    if (src_room < burst_bytes) begin
      burst_bytes = src_room;
    end
    if (dst_room < burst_bytes) begin
      burst_bytes = dst_room;
    end
  end

  assign beats      = beats_t'(burst_bytes >> OffsetWidth);
  assign last_burst = (burst_bytes == rem_q);

  assign rd_desc_o = '{addr: src_q, beats: beats, last: last_burst};
  assign wr_desc_o = '{addr: dst_q, beats: beats, last: last_burst};
  assign rd_valid_o = rd_pend_q;
  assign wr_valid_o = wr_pend_q;

  // each side may accept in a different cycle
  assign rd_left   = rd_pend_q && !rd_ready_i;
  assign wr_left   = wr_pend_q && !wr_ready_i;
  assign pair_done = (rd_pend_q || wr_pend_q) && !rd_left && !wr_left;

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= 1'b0;
      rd_pend_q   <= 1'b0;
      wr_pend_q   <= 1'b0;
    end else begin
      if (take_nz) begin
        in_flight_q <= 1'b1;
      end else if (trans_complete_i) begin
        in_flight_q <= 1'b0;
      end
      if (take_nz) begin
        rd_pend_q <= 1'b1;
        wr_pend_q <= 1'b1;
      end else if (pair_done) begin
        // both sides took it, offer the next one unless done
        rd_pend_q <= !last_burst;
        wr_pend_q <= !last_burst;
      end else begin
        rd_pend_q <= rd_left;
        wr_pend_q <= wr_left;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_nz) begin
      src_q <= req_i.src;
      dst_q <= req_i.dst;
      rem_q <= req_i.num_bytes;
    end else if (pair_done) begin
      src_q <= src_q + addr_t'(burst_bytes);
      dst_q <= dst_q + addr_t'(burst_bytes);
      rem_q <= rem_q - burst_bytes;
    end
  end

  assign busy_o = in_flight_q;

  // the cutter works in whole words only
  a_len_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    take |-> (req_i.num_bytes[OffsetWidth-1:0] == '0));

endmodule

//--- rtl/dma_read_engine.sv
// reads one word per grant; buf_usage_i must come from the word buffer it pushes into
`timescale 1ns/1ps

module dma_read_engine import dma_pkg::*; #(
  parameter int unsigned BufDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  burst_desc_t                   desc_i,
  input  logic                          desc_valid_i,
  output logic                          desc_ready_o,
  output mem_req_t                      mem_req_o,
  input  logic                          gnt_i,
  input  logic                          rvalid_i,
  input  data_t                         rdata_i,
  output logic                          buf_push_o,
  output data_t                         buf_data_o,
  input  logic [$clog2(BufDepth+1)-1:0] buf_usage_i,
  output logic                          busy_o
);

  localparam int unsigned CntWidth = $clog2(BufDepth + 1);

  addr_t               addr_q;
  beats_t              beats_left_q;
  // reads granted whose data has not come back yet
  logic [CntWidth-1:0] out_q;
  logic [CntWidth:0]   fill;
  logic                room;

  // buffer words plus words still on the way
  assign fill = {1'b0, buf_usage_i} + {1'b0, out_q};
  assign room = (fill < (CntWidth + 1)'(BufDepth));

  // a new burst only when the previous one is fully issued
  assign desc_ready_o = (beats_left_q == '0);

  assign mem_req_o.valid = (beats_left_q != '0) && room;
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_left_q <= '0;
      out_q        <= '0;
    end else begin
      if (desc_valid_i && desc_ready_o) begin
        beats_left_q <= desc_i.beats;
      end else if (gnt_i) begin
        beats_left_q <= beats_left_q - 1'b1;
      end
      // outstanding read counter
      if (gnt_i && !rvalid_i) begin
        out_q <= out_q + 1'b1;
      end else if (rvalid_i && !gnt_i) begin
        out_q <= out_q - 1'b1;
      end
    end
  end

  // word address walk
  always_ff @(posedge clk_i) begin
    if (desc_valid_i && desc_ready_o) begin
      addr_q <= desc_i.addr;
    end else if (gnt_i) begin
      addr_q <= addr_q + addr_t'(StrbBytes);
    end
  end

  // returned words go straight into the buffer
  assign buf_push_o = rvalid_i;
  assign buf_data_o = rdata_i;

  assign busy_o = (beats_left_q != '0) || (out_q != '0);

endmodule

//--- rtl/dma_write_engine.sv
// posted writes, one buffer word per grant; completion is combinational from the grant
`timescale 1ns/1ps

module dma_write_engine import dma_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  burst_desc_t desc_i,
  input  logic        desc_valid_i,
  output logic        desc_ready_o,
  input  data_t       buf_data_i,
  input  logic        buf_empty_i,
  output logic        buf_pop_o,
  output mem_req_t    mem_req_o,
  input  logic        gnt_i,
  output logic        trans_complete_o,
  output logic        busy_o
);

  addr_t  addr_q;
  beats_t beats_left_q;
  // burst closes the request
  logic   last_q;

  assign desc_ready_o = (beats_left_q == '0);

  // write only with a word at the buffer head
  assign mem_req_o.valid = (beats_left_q != '0) && !buf_empty_i;
  assign mem_req_o.we    = 1'b1;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = buf_data_i;

  // posted write, the word leaves at its grant
  assign buf_pop_o = gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_left_q <= '0;
    end else if (desc_valid_i && desc_ready_o) begin
      beats_left_q <= desc_i.beats;
    end else if (gnt_i) begin
      beats_left_q <= beats_left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_valid_i && desc_ready_o) begin
      addr_q <= desc_i.addr;
      last_q <= desc_i.last;
    end else if (gnt_i) begin
      addr_q <= addr_q + addr_t'(StrbBytes);
    end
  end

  // final beat of the final burst
  assign trans_complete_o = gnt_i && last_q && (beats_left_q == beats_t'(1));

  assign busy_o = (beats_left_q != '0);

endmodule

//--- rtl/dma_mem_arbiter.sv
// two requesters, round robin; a request once shown is held until its grant
`timescale 1ns/1ps

module dma_mem_arbiter import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t rd_req_i,
  input  mem_req_t wr_req_i,
  output logic     rd_gnt_o,
  output logic     wr_gnt_o,
  output mem_req_t mem_req_o,
  input  logic     mem_gnt_i
);

  // select encoding: 0 read engine, 1 write engine
  logic prio_q;
  logic lock_q, sel_q;
  logic sel;

  always_comb begin
    if (lock_q) begin
      // keep the choice that is waiting for gnt
      sel = sel_q;
    end else if (rd_req_i.valid && wr_req_i.valid) begin
      sel = prio_q;
    end else begin
      sel = !rd_req_i.valid;
    end
  end

  assign mem_req_o = sel ? wr_req_i : rd_req_i;
  assign rd_gnt_o  = mem_gnt_i && !sel && rd_req_i.valid;
  assign wr_gnt_o  = mem_gnt_i && sel && wr_req_i.valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
    end else if (mem_req_o.valid) begin
      if (mem_gnt_i) begin
        lock_q <= 1'b0;
        // other side goes first next time
        prio_q <= !sel;
      end else begin
        lock_q <= 1'b1;
        sel_q  <= sel;
      end
    end
  end

  a_one_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rd_gnt_o && wr_gnt_o));
  // engines must hold a waiting request unchanged
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.valid && !mem_gnt_i) |=> $stable(mem_req_o));

endmodule

//--- rtl/dma_backend.sv
// word-aligned copy backend; src, dst and num_bytes must be multiples of the word size
`timescale 1ns/1ps

module dma_backend import dma_pkg::*; #(
  parameter int unsigned ReqDepth  = 4,
  parameter int unsigned BufDepth  = 4,
  parameter int unsigned MaxBeats  = 8,
  parameter int unsigned PageBytes = 64
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  dma_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     idle_o,
  output logic     trans_complete_o
);

  // request queue
  dma_req_t    fifo_req;
  logic        req_full, req_empty, split_ready;
  // splitter to engines
  burst_desc_t rd_desc, wr_desc;
  logic        rd_desc_valid, rd_desc_ready, wr_desc_valid, wr_desc_ready;
  // word buffer
  logic        buf_push, buf_pop, buf_empty;
  data_t       buf_wdata, buf_rdata;
  logic [$clog2(BufDepth+1)-1:0] buf_usage;
  // memory side
  mem_req_t    rd_mem_req, wr_mem_req;
  logic        rd_gnt, wr_gnt;
  logic        split_busy, rd_busy, wr_busy;

  // ----------------------------------------------------------
  // request intake
  // ----------------------------------------------------------
  assign req_ready_o = !req_full;

  dma_fifo #(
    .Depth  (ReqDepth),
    .elem_t (dma_req_t)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_valid_i && req_ready_o),
    .data_i  (req_i),
    .full_o  (req_full),
    .pop_i   (split_ready && !req_empty),
    .data_o  (fifo_req),
    .empty_o (req_empty),
    .usage_o ()
  );

  dma_burst_splitter #(
    .MaxBeats  (MaxBeats),
    .PageBytes (PageBytes)
  ) u_splitter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (fifo_req),
    .req_valid_i      (!req_empty),
    .req_ready_o      (split_ready),
    .rd_desc_o        (rd_desc),
    .rd_valid_o       (rd_desc_valid),
    .rd_ready_i       (rd_desc_ready),
    .wr_desc_o        (wr_desc),
    .wr_valid_o       (wr_desc_valid),
    .wr_ready_i       (wr_desc_ready),
    .trans_complete_i (trans_complete_o),
    .busy_o           (split_busy)
  );

  // ----------------------------------------------------------
  // data movers
  // ----------------------------------------------------------
  dma_read_engine #(
    .BufDepth (BufDepth)
  ) u_read_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .desc_i       (rd_desc),
    .desc_valid_i (rd_desc_valid),
    .desc_ready_o (rd_desc_ready),
    .mem_req_o    (rd_mem_req),
    .gnt_i        (rd_gnt),
    .rvalid_i     (mem_rsp_i.rvalid),
    .rdata_i      (mem_rsp_i.rdata),
    .buf_push_o   (buf_push),
    .buf_data_o   (buf_wdata),
    .buf_usage_i  (buf_usage),
    .busy_o       (rd_busy)
  );

  dma_fifo #(
    .Depth  (BufDepth),
    .elem_t (data_t)
  ) u_word_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (buf_push),
    .data_i  (buf_wdata),
    .full_o  (),
    .pop_i   (buf_pop),
    .data_o  (buf_rdata),
    .empty_o (buf_empty),
    .usage_o (buf_usage)
  );

  dma_write_engine u_write_engine (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .desc_i           (wr_desc),
    .desc_valid_i     (wr_desc_valid),
    .desc_ready_o     (wr_desc_ready),
    .buf_data_i       (buf_rdata),
    .buf_empty_i      (buf_empty),
    .buf_pop_o        (buf_pop),
    .mem_req_o        (wr_mem_req),
    .gnt_i            (wr_gnt),
    .trans_complete_o (trans_complete_o),
    .busy_o           (wr_busy)
  );

  dma_mem_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_mem_req),
    .wr_req_i  (wr_mem_req),
    .rd_gnt_o  (rd_gnt),
    .wr_gnt_o  (wr_gnt),
    .mem_req_o (mem_req_o),
    .mem_gnt_i (mem_rsp_i.gnt)
  );

  // nothing queued and no block working
  assign idle_o = !(!req_empty || split_busy || rd_busy || wr_busy);

endmodule

//--- tests/tb_mem_model.sv
// word memory over the full address space; gnt is a registered coin gated by gnt_en_i
`timescale 1ns/1ps

module tb_mem_model import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     gnt_en_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned NumWords = 2 ** (AddrWidth - OffsetWidth);

  // one entry per word of the byte address space
  data_t  mem [NumWords];
  integer seed;
  logic   coin_q;
  logic   rvalid_q;
  data_t  rdata_q;
  logic   access;
  int     index;

  // fill pattern built from the full byte address
  initial begin
    seed = 32'h03a5_b0b7;
    for (int i = 0; i < NumWords; i++) begin
      mem[i] = {~addr_t'(i * StrbBytes), addr_t'(i * StrbBytes) ^ addr_t'(16'h5a3c)};
    end
  end

  assign access = mem_req_i.valid && mem_rsp_o.gnt;
  assign index  = int'(mem_req_i.addr >> OffsetWidth);

  // grant about three cycles in four, no path from the request
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      coin_q   <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      coin_q   <= (($random(seed) & 3) != 0);
      rvalid_q <= access && !mem_req_i.we;
      if (access && !mem_req_i.we) begin
        rdata_q <= mem[index];
      end
      // posted write lands at the grant edge
      if (access && mem_req_i.we) begin
        mem[index] <= mem_req_i.wdata;
      end
    end
  end

  assign mem_rsp_o = '{gnt: coin_q && gnt_en_i, rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- tests/tb_dma_backend.sv
// copy regions never overlap; whole memory is compared against the shadow after each completion
`timescale 1ns/1ps

module tb_dma_backend import dma_pkg::*;;

  localparam int unsigned ReqDepth  = 4;
  localparam int unsigned BufDepth  = 4;
  localparam int unsigned MaxBeats  = 8;
  localparam int unsigned PageBytes = 64;
  localparam int unsigned PageBits  = $clog2(PageBytes);
  localparam int unsigned NumWords  = 2 ** (AddrWidth - OffsetWidth);
  // words of all copies plus one for the zero-byte request
  localparam int unsigned TestWords = 8 + 40 + 32 + (ReqDepth + 2) * 6 + 1;

  logic     clk = 1'b0;
  logic     rst_n;
  dma_req_t req;
  logic     req_valid, req_ready;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     idle, trans_complete;
  logic     gnt_en;

  data_t       shadow [NumWords];
  dma_req_t    pending [$];
  integer      seed = 32'h03a5_b0b7;
  int unsigned completions, cycle;
  int unsigned wr_cnt, rd_cnt, last_wr_cycle, last_rd_cycle;

  always #20 clk = ~clk;

  dma_backend #(
    .ReqDepth  (ReqDepth),
    .BufDepth  (BufDepth),
    .MaxBeats  (MaxBeats),
    .PageBytes (PageBytes)
  ) u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_i            (req),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .mem_req_o        (mem_req),
    .mem_rsp_i        (mem_rsp),
    .idle_o           (idle),
    .trans_complete_o (trans_complete)
  );

  tb_mem_model u_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .gnt_en_i  (gnt_en),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  // ------------------------------------------------------------
  // reference model and compare tasks
  // ------------------------------------------------------------
  function automatic int word_count(input dma_req_t r);
    return int'(r.num_bytes) >> OffsetWidth;
  endfunction

  function automatic int word_index(input addr_t a);
    return int'(a >> OffsetWidth);
  endfunction

  // apply one finished copy to the shadow image word by word
  function automatic void ref_copy(input dma_req_t r);
    for (int i = 0; i < word_count(r); i++) begin
      shadow[word_index(r.dst + addr_t'(i * StrbBytes))] =
        shadow[word_index(r.src + addr_t'(i * StrbBytes))];
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_word(input string name, input addr_t where, input data_t act,
                            input data_t exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s @0x%04h: got 0x%08h, expected 0x%08h",
                               name, where, act, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t act, input addr_t exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%04h, expected 0x%04h", name, act, exp));
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, act, exp));
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < NumWords; i++) begin
      check_word("u_mem.mem", addr_t'(i * StrbBytes), u_mem.mem[i], shadow[i]);
    end
  endtask

  // ------------------------------------------------------------
  // bus monitor and completion checker
  // ------------------------------------------------------------
  task automatic observe_access();
    dma_req_t head;
    addr_t    exp_a;
    if (pending.size() == 0) begin
      report_failure("memory access seen while no request was in flight");
    end
    head = pending[0];
    if (mem_req.we) begin
      if (wr_cnt >= word_count(head)) begin
        report_failure("more writes than the request holds");
      end
      // writes must come in ascending destination order
      exp_a = head.dst + addr_t'(wr_cnt * StrbBytes);
      check_addr("mem_req_o.addr (write)", mem_req.addr, exp_a);
      check_word("mem_req_o.wdata", mem_req.addr, mem_req.wdata,
                 shadow[word_index(head.src + addr_t'(wr_cnt * StrbBytes))]);
      // bursts are separated by a free cycle, so a page start must follow a break
      if (wr_cnt != 0 && mem_req.addr[PageBits-1:0] == '0 && cycle == last_wr_cycle + 1) begin
        report_failure("a write burst ran across a destination page boundary");
      end
      last_wr_cycle = cycle;
      wr_cnt++;
    end else begin
      if (rd_cnt >= word_count(head)) begin
        report_failure("more reads than the request holds");
      end
      exp_a = head.src + addr_t'(rd_cnt * StrbBytes);
      check_addr("mem_req_o.addr (read)", mem_req.addr, exp_a);
      if (rd_cnt != 0 && mem_req.addr[PageBits-1:0] == '0 && cycle == last_rd_cycle + 1) begin
        report_failure("a read burst ran across a source page boundary");
      end
      last_rd_cycle = cycle;
      rd_cnt++;
    end
  endtask

  task automatic close_request();
    dma_req_t head;
    if (pending.size() == 0) begin
      report_failure("trans_complete_o pulsed with no request in flight");
    end
    head = pending.pop_front();
    check_count("write beats", wr_cnt, word_count(head));
    check_count("read beats", rd_cnt, word_count(head));
    // last write lands at this edge
    @(posedge clk);
    #1;
    ref_copy(head);
    compare_memory();
    wr_cnt = 0;
    rd_cnt = 0;
    completions++;
  endtask

  // sample between edges where every DUT output is settled
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        cycle++;
        if (mem_req.valid && mem_rsp.gnt) begin
          observe_access();
        end
        if (trans_complete) begin
          close_request();
        end
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  function automatic dma_req_t make_req(input addr_t src, input addr_t dst,
                                        input int unsigned bytes);
    dma_req_t r;
    r.src       = src;
    r.dst       = dst;
    r.num_bytes = len_t'(bytes);
    return r;
  endfunction

  // valid stays high on return so requests can follow back to back
  task automatic send_req(input dma_req_t r);
    logic taken;
    req       = r;
    req_valid = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #2;
    end
    if (r.num_bytes != '0) begin
      pending.push_back(r);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!idle) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  initial begin
    repeat (200 * TestWords) @(posedge clk);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    addr_t src, dst;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    gnt_en    = 1'b1;
    // shadow starts as the model's fill pattern
    #1;
    for (int i = 0; i < NumWords; i++) begin
      shadow[i] = u_mem.mem[i];
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // aligned copy inside one page
    send_req(make_req(16'h0100, 16'h0800, 32));
    req_valid = 1'b0;
    wait_idle();
    check_count("completions", completions, 1);

    // source and destination cross pages at different points
    send_req(make_req(16'h0134, 16'h0a28, 160));
    req_valid = 1'b0;
    wait_idle();
    check_count("completions", completions, 2);

    // random placement under random grants
    src = addr_t'(32'h4000 | ($random(seed) & 32'h0ffc));
    dst = addr_t'(32'h6000 | ($random(seed) & 32'h0ffc));
    send_req(make_req(src, dst, 128));
    req_valid = 1'b0;
    wait_idle();
    check_count("completions", completions, 3);

    // grants held so one request stays in flight while the FIFO fills
    gnt_en = 1'b0;
    for (int k = 0; k <= ReqDepth; k++) begin
      send_req(make_req(addr_t'(16'h7030 + 16'h40 * k), addr_t'(16'h8038 + 16'h40 * k), 24));
    end
    req_valid = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (req_ready) begin
      report_failure("req_ready_o stayed high with the request FIFO full");
    end
    @(posedge clk);
    #2;
    gnt_en = 1'b1;
    send_req(make_req(16'h7030 + 16'h40 * (ReqDepth + 1), 16'h8038 + 16'h40 * (ReqDepth + 1), 24));
    req_valid = 1'b0;
    wait_idle();
    check_count("completions", completions, 3 + ReqDepth + 2);

    // a zero-byte request makes no access and no pulse and leaves the DUT idle
    send_req(make_req(16'h0100, 16'h0900, 0));
    req_valid = 1'b0;
    repeat (20) @(posedge clk);
    @(negedge clk);
    check_count("completions", completions, 3 + ReqDepth + 2);
    if (!idle) begin
      report_failure("idle_o did not return high after all traffic ended");
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- files.f
rtl/dma_pkg.sv
rtl/dma_fifo.sv
rtl/dma_burst_splitter.sv
rtl/dma_read_engine.sv
rtl/dma_write_engine.sv
rtl/dma_mem_arbiter.sv
rtl/dma_backend.sv
tests/tb_mem_model.sv
tests/tb_dma_backend.sv
